// File: verilog/tinyv_defines.svh
// ==========================================================
// tinyv core sizing
// Data width, register count, trace buffer depth and
// retirement order counter width
// ==========================================================
`ifndef TINYV_DEFINES_SVH
`define TINYV_DEFINES_SVH

// Data and address width
`define TINYV_XLEN 32

// Architectural registers, x0 hardwired to zero
`define TINYV_NREGS 32

// Trace FIFO entries, power of two
`define TINYV_TRACE_DEPTH 4

`define TINYV_ORDER_W 32

`endif

// File: verilog/tinyv_core_pkg.sv
// ==========================================================
// tinyv core package
// Opcode and funct encodings, internal ALU operation codes
// and the instruction word union
// ==========================================================
package tinyv_core_pkg;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // Function fields
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // Operation selected by decode, carried to execute
  localparam int unsigned OP_W = 3;
  localparam logic [OP_W-1:0] ALU_ADDI = 3'd0;
  localparam logic [OP_W-1:0] ALU_ADD  = 3'd1;
  localparam logic [OP_W-1:0] ALU_SUB  = 3'd2;
  localparam logic [OP_W-1:0] ALU_XOR  = 3'd3;
  localparam logic [OP_W-1:0] ALU_LUI  = 3'd4;

  // One instruction word, read as R-type or I-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_u;

endpackage

// File: verilog/tinyv_trace_pkg.sv
// ==========================================================
// tinyv trace package
// Trap cause codes carried in each retirement record
// ==========================================================
package tinyv_trace_pkg;

  localparam int unsigned CAUSE_W = 2;

  // Normal retirement
  localparam logic [CAUSE_W-1:0] CAUSE_NONE      = 2'd0;
  // Encoding outside the supported subset
  localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL   = 2'd1;
  // Instruction bus returned an error
  localparam logic [CAUSE_W-1:0] CAUSE_FETCH_ERR = 2'd2;

endpackage

// File: verilog/tinyv_fetch.sv
// ==========================================================
// tinyv fetch stage
// Program counter and req/gnt/rvalid instruction fetch
// ==========================================================
`timescale 1ns/1ns
`include "tinyv_defines.svh"

module tinyv_fetch (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   fetch_enable_i,
  input  logic [`TINYV_XLEN-1:0] boot_addr_i,
  output logic                   instr_req_o,
  output logic [`TINYV_XLEN-1:0] instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  logic [31:0]            instr_rdata_i,
  input  logic                   instr_err_i,
  input  logic                   redirect_i,
  input  logic [`TINYV_XLEN-1:0] redirect_pc_i,
  output logic                   valid_o,
  output logic [`TINYV_XLEN-1:0] pc_o,
  output logic [31:0]            insn_o,
  output logic                   err_o
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_REQ  = 2'd1;
  localparam logic [1:0] S_WAIT = 2'd2;

  logic [1:0]            state_q;
  logic                  boot_q;
  logic                  ready_q;
  logic                  valid_q;
  logic [`TINYV_XLEN-1:0] pc_q;
  logic [31:0]           insn_q;
  logic                  err_q;
  logic                  start;

  // Leave idle once a pc is ready and fetching is allowed
  assign start = fetch_enable_i && (ready_q || redirect_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      boot_q  <= 1'b1;
      ready_q <= 1'b1;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (redirect_i) begin
            ready_q <= 1'b1;
          end
          if (start) begin
            state_q <= S_REQ;
            ready_q <= 1'b0;
            boot_q  <= 1'b0;
          end
        end
        S_REQ: begin
          if (instr_gnt_i) begin
            state_q <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (instr_rvalid_i) begin
            valid_q <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // PC and fetched word
  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && boot_q) begin
      pc_q <= boot_addr_i;
    end else if (state_q == S_IDLE && redirect_i) begin
      pc_q <= redirect_pc_i;
    end
    if (state_q == S_WAIT && instr_rvalid_i) begin
      insn_q <= instr_rdata_i;
      err_q  <= instr_err_i;
    end
  end

  assign instr_req_o  = (state_q == S_REQ);
  assign instr_addr_o = pc_q;
  assign valid_o      = valid_q;
  assign pc_o         = pc_q;
  assign insn_o       = insn_q;
  assign err_o        = err_q;

endmodule

// File: verilog/tinyv_decode.sv
// ==========================================================
// tinyv decode stage
// Registered decode of one instruction into ALU, writeback
// and branch controls with its immediate
// ==========================================================
`timescale 1ns/1ns
`include "tinyv_defines.svh"

module tinyv_decode (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          valid_i,
  input  logic [`TINYV_XLEN-1:0]        pc_i,
  input  logic [31:0]                   insn_i,
  input  logic                          err_i,
  output logic                          valid_o,
  output logic [`TINYV_XLEN-1:0]        pc_o,
  output logic [31:0]                   insn_o,
  output logic [tinyv_core_pkg::OP_W-1:0] op_o,
  output logic [4:0]                    rd_o,
  output logic [4:0]                    rs1_o,
  output logic [4:0]                    rs2_o,
  output logic [`TINYV_XLEN-1:0]        imm_o,
  output logic                          we_o,
  output logic                          branch_o,
  output logic                          illegal_o,
  output logic                          err_o
);

  tinyv_core_pkg::instr_u          insn;
  logic [tinyv_core_pkg::OP_W-1:0] op_d;
  logic [`TINYV_XLEN-1:0]          imm_d;
  logic                            we_d;
  logic                            branch_d;
  logic                            illegal_d;

  assign insn = insn_i;

  always_comb begin
    op_d      = tinyv_core_pkg::ALU_ADD;
    imm_d     = {{(`TINYV_XLEN-12){insn.i.imm[11]}}, insn.i.imm};
    we_d      = 1'b0;
    branch_d  = 1'b0;
    illegal_d = 1'b0;
    case (insn.r.opcode)
      tinyv_core_pkg::OPC_OP_IMM: begin
        op_d      = tinyv_core_pkg::ALU_ADDI;
        we_d      = (insn.i.funct3 == tinyv_core_pkg::F3_ADD);
        illegal_d = !we_d;
      end
      tinyv_core_pkg::OPC_OP: begin
        we_d = 1'b1;
        if (insn.r.funct7 == 7'd0 && insn.r.funct3 == tinyv_core_pkg::F3_ADD) begin
          op_d = tinyv_core_pkg::ALU_ADD;
        end else if (insn.r.funct7 == tinyv_core_pkg::F7_SUB &&
                     insn.r.funct3 == tinyv_core_pkg::F3_ADD) begin
          op_d = tinyv_core_pkg::ALU_SUB;
        end else if (insn.r.funct7 == 7'd0 && insn.r.funct3 == tinyv_core_pkg::F3_XOR) begin
          op_d = tinyv_core_pkg::ALU_XOR;
        end else begin
          we_d      = 1'b0;
          illegal_d = 1'b1;
        end
      end
      tinyv_core_pkg::OPC_LUI: begin
        op_d  = tinyv_core_pkg::ALU_LUI;
        imm_d = {insn_i[31:12], 12'd0};
        we_d  = 1'b1;
      end
      tinyv_core_pkg::OPC_BRANCH: begin
        // B-type offset, scattered across the word
        op_d      = tinyv_core_pkg::ALU_SUB;
        imm_d     = {{(`TINYV_XLEN-12){insn_i[31]}}, insn_i[7], insn_i[30:25],
                     insn_i[11:8], 1'b0};
        branch_d  = (insn.r.funct3 == tinyv_core_pkg::F3_BEQ);
        illegal_d = !branch_d;
      end
      default: illegal_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      pc_o      <= pc_i;
      insn_o    <= insn_i;
      op_o      <= op_d;
      rd_o      <= insn.r.rd;
      rs1_o     <= insn.r.rs1;
      rs2_o     <= insn.r.rs2;
      imm_o     <= imm_d;
      we_o      <= we_d;
      branch_o  <= branch_d;
      illegal_o <= illegal_d;
      err_o     <= err_i;
    end
  end

endmodule

// File: verilog/tinyv_execute.sv
// ==========================================================
// tinyv execute stage
// Register file, ALU, branch resolution and the retirement
// record handed to the tracer
// ==========================================================
`timescale 1ns/1ns
`include "tinyv_defines.svh"

module tinyv_execute (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             valid_i,
  input  logic [`TINYV_XLEN-1:0]           pc_i,
  input  logic [31:0]                      insn_i,
  input  logic [tinyv_core_pkg::OP_W-1:0]  op_i,
  input  logic [4:0]                       rd_i,
  input  logic [4:0]                       rs1_i,
  input  logic [4:0]                       rs2_i,
  input  logic [`TINYV_XLEN-1:0]           imm_i,
  input  logic                             we_i,
  input  logic                             branch_i,
  input  logic                             illegal_i,
  input  logic                             err_i,
  input  logic                             rec_ready_i,
  output logic                             rec_valid_o,
  output logic [`TINYV_XLEN-1:0]           rec_pc_o,
  output logic [31:0]                      rec_insn_o,
  output logic [4:0]                       rec_rd_o,
  output logic [`TINYV_XLEN-1:0]           rec_wdata_o,
  output logic [`TINYV_XLEN-1:0]           rec_next_pc_o,
  output logic [tinyv_trace_pkg::CAUSE_W-1:0] rec_cause_o,
  output logic                             done_o,
  output logic [`TINYV_XLEN-1:0]           next_pc_o
);

  logic [`TINYV_XLEN-1:0] rf_q [`TINYV_NREGS];
  logic [`TINYV_XLEN-1:0] op_a;
  logic [`TINYV_XLEN-1:0] op_b;
  logic [`TINYV_XLEN-1:0] result;
  logic [`TINYV_XLEN-1:0] next_pc;
  logic [tinyv_trace_pkg::CAUSE_W-1:0] cause;
  logic                   wr;

  // x0 reads as zero whatever was stored
  assign op_a = (rs1_i == 5'd0) ? '0 : rf_q[rs1_i];
  assign op_b = (rs2_i == 5'd0) ? '0 : rf_q[rs2_i];

  always_comb begin
    case (op_i)
      tinyv_core_pkg::ALU_ADDI: result = op_a + imm_i;
      tinyv_core_pkg::ALU_ADD:  result = op_a + op_b;
      tinyv_core_pkg::ALU_SUB:  result = op_a - op_b;
      tinyv_core_pkg::ALU_XOR:  result = op_a ^ op_b;
      tinyv_core_pkg::ALU_LUI:  result = imm_i;
      default:                  result = '0;
    endcase
  end

  // Fetch error outranks an illegal encoding
  assign cause = err_i     ? tinyv_trace_pkg::CAUSE_FETCH_ERR :
                 illegal_i ? tinyv_trace_pkg::CAUSE_ILLEGAL   :
                             tinyv_trace_pkg::CAUSE_NONE;

  assign wr      = we_i && (cause == tinyv_trace_pkg::CAUSE_NONE) && (rd_i != 5'd0);
  assign next_pc = (branch_i && (cause == tinyv_trace_pkg::CAUSE_NONE) && (op_a == op_b)) ?
                   pc_i + imm_i : pc_i + `TINYV_XLEN'd4;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rec_valid_o <= 1'b0;
    end else if (valid_i) begin
      rec_valid_o <= 1'b1;
    end else if (rec_ready_i) begin
      rec_valid_o <= 1'b0;
    end
  end

  // Record held until the tracer takes it
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rec_pc_o      <= pc_i;
      rec_insn_o    <= insn_i;
      rec_rd_o      <= wr ? rd_i : 5'd0;
      rec_wdata_o   <= wr ? result : '0;
      rec_next_pc_o <= next_pc;
      rec_cause_o   <= cause;
    end
  end

  // Writeback happens only once the record is accepted
  always_ff @(posedge clk_i) begin
    if (done_o && rec_rd_o != 5'd0) begin
      rf_q[rec_rd_o] <= rec_wdata_o;
    end
  end

  assign done_o    = rec_valid_o && rec_ready_i;
  assign next_pc_o = rec_next_pc_o;

endmodule

// File: verilog/tinyv_tracer.sv
// ==========================================================
// tinyv tracer
// Numbers retirement records, buffers them in a FIFO and
// streams them out under valid/ready
// ==========================================================
`timescale 1ns/1ns
`include "tinyv_defines.svh"

module tinyv_tracer (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                rec_valid_i,
  input  logic [`TINYV_XLEN-1:0]              rec_pc_i,
  input  logic [31:0]                         rec_insn_i,
  input  logic [4:0]                          rec_rd_i,
  input  logic [`TINYV_XLEN-1:0]              rec_wdata_i,
  input  logic [`TINYV_XLEN-1:0]              rec_next_pc_i,
  input  logic [tinyv_trace_pkg::CAUSE_W-1:0] rec_cause_i,
  output logic                                rec_ready_o,
  input  logic                                trace_ready_i,
  output logic                                trace_valid_o,
  output logic [`TINYV_ORDER_W-1:0]           trace_order_o,
  output logic [`TINYV_XLEN-1:0]              trace_pc_o,
  output logic [31:0]                         trace_insn_o,
  output logic [4:0]                          trace_rd_o,
  output logic [`TINYV_XLEN-1:0]              trace_wdata_o,
  output logic [`TINYV_XLEN-1:0]              trace_next_pc_o,
  output logic [tinyv_trace_pkg::CAUSE_W-1:0] trace_cause_o
);

  localparam int unsigned PTR_W = $clog2(`TINYV_TRACE_DEPTH);
  localparam int unsigned REC_W = `TINYV_ORDER_W + 3 * `TINYV_XLEN + 32 + 5 +
                                  tinyv_trace_pkg::CAUSE_W;

  logic [REC_W-1:0]          mem_q [`TINYV_TRACE_DEPTH];
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [PTR_W:0]            count_q;
  logic [`TINYV_ORDER_W-1:0] order_q;
  logic                      push;
  logic                      pop;

  assign rec_ready_o   = (count_q != (PTR_W+1)'(`TINYV_TRACE_DEPTH));
  assign trace_valid_o = (count_q != '0);
  assign push          = rec_valid_i && rec_ready_o;
  assign pop           = trace_valid_o && trace_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      order_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        order_q  <= order_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= {order_q, rec_pc_i, rec_insn_i, rec_rd_i,
                          rec_wdata_i, rec_next_pc_i, rec_cause_i};
    end
  end

  // Head entry stays put until popped
  assign {trace_order_o, trace_pc_o, trace_insn_o, trace_rd_o,
          trace_wdata_o, trace_next_pc_o, trace_cause_o} = mem_q[rd_ptr_q];

endmodule

// File: verilog/tinyv_top_tracing.sv
// ==========================================================
// tinyv top level with tracing
// Fetch, decode, execute and tracer stages in one core
// ==========================================================
`timescale 1ns/1ns
`include "tinyv_defines.svh"

module tinyv_top_tracing (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                fetch_enable_i,
  input  logic [`TINYV_XLEN-1:0]              boot_addr_i,

  // Instruction memory interface
  output logic                                instr_req_o,
  input  logic                                instr_gnt_i,
  input  logic                                instr_rvalid_i,
  output logic [`TINYV_XLEN-1:0]              instr_addr_o,
  input  logic [31:0]                         instr_rdata_i,
  input  logic                                instr_err_i,

  // Trace stream
  input  logic                                trace_ready_i,
  output logic                                trace_valid_o,
  output logic [`TINYV_ORDER_W-1:0]           trace_order_o,
  output logic [`TINYV_XLEN-1:0]              trace_pc_o,
  output logic [31:0]                         trace_insn_o,
  output logic [4:0]                          trace_rd_o,
  output logic [`TINYV_XLEN-1:0]              trace_wdata_o,
  output logic [`TINYV_XLEN-1:0]              trace_next_pc_o,
  output logic [tinyv_trace_pkg::CAUSE_W-1:0] trace_cause_o
);

  logic                                f_valid;
  logic [`TINYV_XLEN-1:0]              f_pc;
  logic [31:0]                         f_insn;
  logic                                f_err;

  logic                                d_valid;
  logic [`TINYV_XLEN-1:0]              d_pc;
  logic [31:0]                         d_insn;
  logic [tinyv_core_pkg::OP_W-1:0]     d_op;
  logic [4:0]                          d_rd;
  logic [4:0]                          d_rs1;
  logic [4:0]                          d_rs2;
  logic [`TINYV_XLEN-1:0]              d_imm;
  logic                                d_we;
  logic                                d_branch;
  logic                                d_illegal;
  logic                                d_err;

  logic                                r_valid;
  logic                                r_ready;
  logic [`TINYV_XLEN-1:0]              r_pc;
  logic [31:0]                         r_insn;
  logic [4:0]                          r_rd;
  logic [`TINYV_XLEN-1:0]              r_wdata;
  logic [`TINYV_XLEN-1:0]              r_next_pc;
  logic [tinyv_trace_pkg::CAUSE_W-1:0] r_cause;

  // Retirement redirect back to fetch
  logic                                x_done;
  logic [`TINYV_XLEN-1:0]              x_next_pc;

  tinyv_fetch u_fetch (
    .clk_i,
    .rst_n_i,
    .fetch_enable_i,
    .boot_addr_i,
    .instr_req_o,
    .instr_addr_o,
    .instr_gnt_i,
    .instr_rvalid_i,
    .instr_rdata_i,
    .instr_err_i,
    .redirect_i    (x_done),
    .redirect_pc_i (x_next_pc),
    .valid_o       (f_valid),
    .pc_o          (f_pc),
    .insn_o        (f_insn),
    .err_o         (f_err)
  );

  tinyv_decode u_decode (
    .clk_i,
    .rst_n_i,
    .valid_i   (f_valid),
    .pc_i      (f_pc),
    .insn_i    (f_insn),
    .err_i     (f_err),
    .valid_o   (d_valid),
    .pc_o      (d_pc),
    .insn_o    (d_insn),
    .op_o      (d_op),
    .rd_o      (d_rd),
    .rs1_o     (d_rs1),
    .rs2_o     (d_rs2),
    .imm_o     (d_imm),
    .we_o      (d_we),
    .branch_o  (d_branch),
    .illegal_o (d_illegal),
    .err_o     (d_err)
  );

  tinyv_execute u_execute (
    .clk_i,
    .rst_n_i,
    .valid_i       (d_valid),
    .pc_i          (d_pc),
    .insn_i        (d_insn),
    .op_i          (d_op),
    .rd_i          (d_rd),
    .rs1_i         (d_rs1),
    .rs2_i         (d_rs2),
    .imm_i         (d_imm),
    .we_i          (d_we),
    .branch_i      (d_branch),
    .illegal_i     (d_illegal),
    .err_i         (d_err),
    .rec_ready_i   (r_ready),
    .rec_valid_o   (r_valid),
    .rec_pc_o      (r_pc),
    .rec_insn_o    (r_insn),
    .rec_rd_o      (r_rd),
    .rec_wdata_o   (r_wdata),
    .rec_next_pc_o (r_next_pc),
    .rec_cause_o   (r_cause),
    .done_o        (x_done),
    .next_pc_o     (x_next_pc)
  );

  tinyv_tracer u_tracer (
    .clk_i,
    .rst_n_i,
    .rec_valid_i   (r_valid),
    .rec_pc_i      (r_pc),
    .rec_insn_i    (r_insn),
    .rec_rd_i      (r_rd),
    .rec_wdata_i   (r_wdata),
    .rec_next_pc_i (r_next_pc),
    .rec_cause_i   (r_cause),
    .rec_ready_o   (r_ready),
    .trace_ready_i,
    .trace_valid_o,
    .trace_order_o,
    .trace_pc_o,
    .trace_insn_o,
    .trace_rd_o,
    .trace_wdata_o,
    .trace_next_pc_o,
    .trace_cause_o
  );

endmodule

// File: sim/tb_clkgen.sv
// ==========================================================
// Testbench clock and reset source
// 8 ns clock, reset held low for the first 5 cycles
// ==========================================================
`timescale 1ns/1ns

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: sim/tinyv_top_sva.sv
// ==========================================================
// Handshake assertions for the tinyv core
// Fetch request hold, trace record hold, trace idle at reset
// ==========================================================
`timescale 1ns/1ns
`include "tinyv_defines.svh"

module tinyv_top_sva (
  input logic                                clk_i,
  input logic                                rst_n_i,
  input logic                                instr_req_o,
  input logic                                instr_gnt_i,
  input logic [`TINYV_XLEN-1:0]              instr_addr_o,
  input logic                                trace_valid_o,
  input logic                                trace_ready_i,
  input logic [`TINYV_ORDER_W-1:0]           trace_order_o,
  input logic [`TINYV_XLEN-1:0]              trace_pc_o,
  input logic [31:0]                         trace_insn_o,
  input logic [4:0]                          trace_rd_o,
  input logic [`TINYV_XLEN-1:0]              trace_wdata_o,
  input logic [`TINYV_XLEN-1:0]              trace_next_pc_o,
  input logic [tinyv_trace_pkg::CAUSE_W-1:0] trace_cause_o
);

  // Request waits with a steady address for its grant
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("fetch request dropped or address moved before grant");

  a_trace_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trace_valid_o && !trace_ready_i |=> trace_valid_o &&
      $stable({trace_order_o, trace_pc_o, trace_insn_o, trace_rd_o, trace_wdata_o,
               trace_next_pc_o, trace_cause_o}))
    else $error("waiting trace record changed or vanished");

  a_trace_idle: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !trace_valid_o)
    else $error("trace valid high right after reset");

endmodule

bind tinyv_top_tracing tinyv_top_sva u_sva (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .instr_req_o     (instr_req_o),
  .instr_gnt_i     (instr_gnt_i),
  .instr_addr_o    (instr_addr_o),
  .trace_valid_o   (trace_valid_o),
  .trace_ready_i   (trace_ready_i),
  .trace_order_o   (trace_order_o),
  .trace_pc_o      (trace_pc_o),
  .trace_insn_o    (trace_insn_o),
  .trace_rd_o      (trace_rd_o),
  .trace_wdata_o   (trace_wdata_o),
  .trace_next_pc_o (trace_next_pc_o),
  .trace_cause_o   (trace_cause_o)
);

// File: sim/tb_tinyv_top.sv
// ==========================================================
// Testbench for the tinyv core with tracing
// Instruction memory model, program table and trace checks
// ==========================================================
`timescale 1ns/1ns
`include "tinyv_defines.svh"

module tb_tinyv_top;

  localparam int NROWS = 13;
  localparam logic [31:0] BOOT = 32'h0000_0100;

  logic                                clk;
  logic                                rst_n;
  logic                                fetch_enable_i;
  logic [`TINYV_XLEN-1:0]              boot_addr_i;
  logic                                instr_req_o;
  logic                                instr_gnt_i;
  logic                                instr_rvalid_i;
  logic [`TINYV_XLEN-1:0]              instr_addr_o;
  logic [31:0]                         instr_rdata_i;
  logic                                instr_err_i;
  logic                                trace_ready_i;
  logic                                trace_valid_o;
  logic [`TINYV_ORDER_W-1:0]           trace_order_o;
  logic [`TINYV_XLEN-1:0]              trace_pc_o;
  logic [31:0]                         trace_insn_o;
  logic [4:0]                          trace_rd_o;
  logic [`TINYV_XLEN-1:0]              trace_wdata_o;
  logic [`TINYV_XLEN-1:0]              trace_next_pc_o;
  logic [tinyv_trace_pkg::CAUSE_W-1:0] trace_cause_o;

  // Program rows in retirement order
  logic [31:0]                         row_pc    [NROWS];
  tinyv_core_pkg::instr_u              row_insn  [NROWS];
  logic                                row_err   [NROWS];
  logic [4:0]                          row_rd    [NROWS];
  logic [31:0]                         row_wdata [NROWS];
  logic [31:0]                         row_npc   [NROWS];
  logic [tinyv_trace_pkg::CAUSE_W-1:0] row_cause [NROWS];

  integer seed = 39;
  int     errors = 0;
  int     seen = 0;
  int     cycles = 0;
  int     mem_state = 0;
  int     gnt_wait = 0;
  int     rv_wait = 0;
  int     rnd;
  int     row_errs;
  int     idx;
  bit     enabled = 1'b0;
  bit     first_seen = 1'b0;

  tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

  tinyv_top_tracing u_tinyv_top_tracing (
    .clk_i (clk),
    .rst_n_i (rst_n),
    .fetch_enable_i, .boot_addr_i,
    .instr_req_o, .instr_gnt_i, .instr_rvalid_i, .instr_addr_o,
    .instr_rdata_i, .instr_err_i,
    .trace_ready_i, .trace_valid_o, .trace_order_o, .trace_pc_o,
    .trace_insn_o, .trace_rd_o, .trace_wdata_o, .trace_next_pc_o,
    .trace_cause_o
  );

  task automatic set_row(input int i, input logic [31:0] pc, input logic [31:0] insn,
                         input logic err, input logic [4:0] rd, input logic [31:0] wdata,
                         input logic [31:0] npc, input logic [1:0] cause);
    row_pc[i]    = pc;
    row_insn[i]  = insn;
    row_err[i]   = err;
    row_rd[i]    = rd;
    row_wdata[i] = wdata;
    row_npc[i]   = npc;
    row_cause[i] = cause;
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input string what, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got x%0d expected x%0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_cause(input string what, input logic [tinyv_trace_pkg::CAUSE_W-1:0] got,
                             input logic [tinyv_trace_pkg::CAUSE_W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic int find_row(input logic [31:0] addr);
    int r;
    r = -1;
    for (int i = 0; i < NROWS; i++) begin
      if (row_pc[i] == addr) begin
        r = i;
      end
    end
    return r;
  endfunction

  always @(posedge clk) begin
    // Trace sink stalls through one long window to force back-pressure
    rnd = $random(seed);
    if (cycles >= 40 && cycles < 90) begin
      trace_ready_i <= 1'b0;
    end else begin
      trace_ready_i <= enabled && ((rnd & 3) != 0);
    end

    // Memory model with random grant and data delays
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    if (mem_state == 0 && instr_req_o && !instr_gnt_i) begin
      if (gnt_wait == 0) begin
        instr_gnt_i <= 1'b1;
        idx = find_row(instr_addr_o);
        mem_state <= 1;
        rnd = $random(seed);
        rv_wait <= rnd & 3;
      end else begin
        gnt_wait <= gnt_wait - 1;
      end
    end else if (mem_state == 1) begin
      if (rv_wait == 0) begin
        instr_rvalid_i <= 1'b1;
        // Unmapped addresses return an illegal opcode
        instr_rdata_i  <= (idx >= 0) ? row_insn[idx] : 32'h0000_007f;
        instr_err_i    <= (idx >= 0) ? row_err[idx] : 1'b0;
        mem_state <= 0;
        rnd = $random(seed);
        gnt_wait <= rnd & 3;
      end else begin
        rv_wait <= rv_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (enabled) begin
      cycles <= cycles + 1;
    end
    if (instr_req_o && !first_seen) begin
      first_seen <= 1'b1;
      check_word("first fetch address", instr_addr_o, BOOT);
    end
    if (trace_valid_o && trace_ready_i && seen < NROWS) begin
      row_errs = errors;
      check_word("order", trace_order_o, seen);
      check_word("pc", trace_pc_o, row_pc[seen]);
      check_word("insn", trace_insn_o, row_insn[seen]);
      check_reg("rd", trace_rd_o, row_rd[seen]);
      check_word("wdata", trace_wdata_o, row_wdata[seen]);
      check_word("next pc", trace_next_pc_o, row_npc[seen]);
      check_cause("cause", trace_cause_o, row_cause[seen]);
      $display("test row %0d pc %h rd field x%0d: %s", seen, row_pc[seen],
               row_insn[seen].r.rd, (errors == row_errs) ? "ok" : "failed");
      seen <= seen + 1;
    end
  end

  initial begin
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = 32'h0;
    instr_err_i    = 1'b0;
    trace_ready_i  = 1'b0;
    set_row(0,  32'h100, 32'h00500093, 1'b0, 5'd1,  32'd5,        32'h104,
            tinyv_trace_pkg::CAUSE_NONE);
    set_row(1,  32'h104, 32'h00500113, 1'b0, 5'd2,  32'd5,        32'h108,
            tinyv_trace_pkg::CAUSE_NONE);
    set_row(2,  32'h108, 32'h002081b3, 1'b0, 5'd3,  32'd10,       32'h10c,
            tinyv_trace_pkg::CAUSE_NONE);
    set_row(3,  32'h10c, 32'h40118233, 1'b0, 5'd4,  32'd5,        32'h110,
            tinyv_trace_pkg::CAUSE_NONE);
    set_row(4,  32'h110, 32'h0021c2b3, 1'b0, 5'd5,  32'd15,       32'h114,
            tinyv_trace_pkg::CAUSE_NONE);
    set_row(5,  32'h114, 32'h12345337, 1'b0, 5'd6,  32'h12345000, 32'h118,
            tinyv_trace_pkg::CAUSE_NONE);
    // Write to x0 reports no destination
    set_row(6,  32'h118, 32'h00700013, 1'b0, 5'd0,  32'd0,        32'h11c,
            tinyv_trace_pkg::CAUSE_NONE);
    set_row(7,  32'h11c, 32'h001003b3, 1'b0, 5'd7,  32'd5,        32'h120,
            tinyv_trace_pkg::CAUSE_NONE);
    // Taken BEQ skips 0x124
    set_row(8,  32'h120, 32'h00208463, 1'b0, 5'd0,  32'd0,        32'h128,
            tinyv_trace_pkg::CAUSE_NONE);
    set_row(9,  32'h128, 32'h00308463, 1'b0, 5'd0,  32'd0,        32'h12c,
            tinyv_trace_pkg::CAUSE_NONE);
    set_row(10, 32'h12c, 32'h0000007f, 1'b0, 5'd0,  32'd0,        32'h130,
            tinyv_trace_pkg::CAUSE_ILLEGAL);
    set_row(11, 32'h130, 32'h00100493, 1'b1, 5'd0,  32'd0,        32'h134,
            tinyv_trace_pkg::CAUSE_FETCH_ERR);
    // Program resumes after the fetch error
    set_row(12, 32'h134, 32'h00100413, 1'b0, 5'd8,  32'd1,        32'h138,
            tinyv_trace_pkg::CAUSE_NONE);

    @(posedge rst_n);
    row_errs = errors;
    repeat (10) begin
      @(posedge clk);
      if (instr_req_o !== 1'b0 || trace_valid_o !== 1'b0) begin
        $display("[ERROR] %0t: activity while fetch is disabled", $time);
        errors++;
      end
    end
    $display("test reset and enable: %s", (errors == row_errs) ? "ok" : "failed");
    fetch_enable_i <= 1'b1;
    enabled <= 1'b1;

    while (seen < NROWS && cycles < NROWS * 40) begin
      @(posedge clk);
    end
    if (seen < NROWS) begin
      $display("Timeout after %0d cycles with %0d of %0d records seen", cycles, seen, NROWS);
      errors++;
    end
    $display("tests done: %0d records checked, %0d errors", seen, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+verilog
verilog/tinyv_core_pkg.sv
verilog/tinyv_trace_pkg.sv
verilog/tinyv_fetch.sv
verilog/tinyv_decode.sv
verilog/tinyv_execute.sv
verilog/tinyv_tracer.sv
verilog/tinyv_top_tracing.sv
sim/tb_clkgen.sv
sim/tinyv_top_sva.sv
sim/tb_tinyv_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the tinyv testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
  -f all.f \
  --top-module tb_tinyv_top \
  -Mdir obj_dir -o sim_tinyv

./obj_dir/sim_tinyv > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
